// ==== logic/modulation_pkg.sv ====
`default_nettype none

package modulation_pkg;

  localparam int IDX_W = 15;
  localparam int REP_W = 32;
  localparam int DIV_W = 16;

  // all ones in a repeat field means the segment loops forever
  localparam logic [REP_W-1:0] REP_INFINITE = '1;

  typedef struct packed {
    logic             req_segment;
    logic [REP_W-1:0] rep_0;
    logic [REP_W-1:0] rep_1;
    logic [IDX_W-1:0] cycle_0;
    logic [IDX_W-1:0] cycle_1;
    logic [DIV_W-1:0] div_0;
    logic [DIV_W-1:0] div_1;
  } mod_settings_t;

  typedef struct packed {
    logic segment;
    logic stop;
  } mod_status_t;

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } swap_state_t;

  // both segments loop forever on a single sample until the host says otherwise
  localparam mod_settings_t SETTINGS_RESET = '{
    req_segment: 1'b0,
    rep_0: REP_INFINITE,
    rep_1: REP_INFINITE,
    default: '0
  };

endpackage

`default_nettype wire

// ==== logic/modulation_settings.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation_settings
  import modulation_pkg::*;
(
  input  wire logic          CLK,
  input  wire logic          arst_n,
  input  wire logic          settings_req,
  input  wire mod_settings_t settings,
  output logic               settings_ack,
  output logic               update,
  output mod_settings_t      cur_settings
);

  logic accept;

  // the pulse cycle is excluded so one request is never taken twice
  assign accept = settings_req && !settings_ack && !update;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      update <= 1'b0;
    end else begin
      update <= accept;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cur_settings <= SETTINGS_RESET;
    end else if (accept) begin
      cur_settings <= settings;
    end
  end

  // ack follows the pulse and is held until the host lets go of req
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      settings_ack <= 1'b0;
    end else if (update) begin
      settings_ack <= 1'b1;
    end else if (!settings_req) begin
      settings_ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/modulation_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation_timer
  import modulation_pkg::*;
(
  input  wire logic             CLK,
  input  wire logic             arst_n,
  input  wire mod_settings_t    cur_settings,
  output logic      [IDX_W-1:0] idx_0,
  output logic      [IDX_W-1:0] idx_1
);

  logic [1:0][IDX_W-1:0] cycle;
  logic [1:0][DIV_W-1:0] div;
  logic [1:0][DIV_W-1:0] div_cnt;
  logic [1:0][IDX_W-1:0] idx;

  assign cycle = {cur_settings.cycle_1, cur_settings.cycle_0};
  assign div   = {cur_settings.div_1, cur_settings.div_0};

  // comparisons use >= so a lowered div or cycle takes effect at the next step
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt <= '0;
      idx     <= '0;
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (div_cnt[s] >= div[s]) begin
          div_cnt[s] <= '0;
          if (idx[s] >= cycle[s]) begin
            idx[s] <= '0;
          end else begin
            idx[s] <= idx[s] + 1'b1;
          end
        end else begin
          div_cnt[s] <= div_cnt[s] + 1'b1;
        end
      end
    end
  end

  assign idx_0 = idx[0];
  assign idx_1 = idx[1];

endmodule

`default_nettype wire

// ==== logic/modulation_swapchain.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation_swapchain
  import modulation_pkg::*;
(
  input  wire logic             CLK,
  input  wire logic             arst_n,
  input  wire logic             update,
  input  wire mod_settings_t    cur_settings,
  input  wire logic [IDX_W-1:0] idx_0,
  input  wire logic [IDX_W-1:0] idx_1,
  output mod_status_t           status,
  output logic      [IDX_W-1:0] idx_0_out,
  output logic      [IDX_W-1:0] idx_1_out
);

  swap_state_t      state;
  logic             req_segment;
  logic [REP_W-1:0] rep;
  logic [REP_W-1:0] loop_cnt;

  logic [REP_W-1:0] new_rep;
  logic [IDX_W-1:0] req_idx;
  logic [IDX_W-1:0] live_idx;
  logic [IDX_W-1:0] live_idx_prev;
  logic             live_wrap;

  assign new_rep = cur_settings.req_segment ? cur_settings.rep_1 : cur_settings.rep_0;
  assign req_idx = req_segment ? idx_1 : idx_0;

  assign live_idx      = status.segment ? idx_1 : idx_0;
  assign live_idx_prev = status.segment ? idx_1_out : idx_0_out;

  // a wrap is seen on the cycle the live index lands on zero
  assign live_wrap = (live_idx != live_idx_prev) && (live_idx == '0);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      status      <= '0;
      state       <= INFINITE_LOOP;
      req_segment <= 1'b0;
      rep         <= '0;
      loop_cnt    <= '0;
    end else if (update) begin
      if (cur_settings.req_segment == status.segment) begin
        status.stop <= 1'b0;
        state       <= INFINITE_LOOP;
      end else if (new_rep == REP_INFINITE) begin
        status.stop    <= 1'b0;
        status.segment <= cur_settings.req_segment;
        state          <= INFINITE_LOOP;
      end else begin
        // finite swaps wait for the requested segment to start over
        rep         <= new_rep;
        req_segment <= cur_settings.req_segment;
        state       <= WAIT_START;
      end
    end else begin
      case (state)
        WAIT_START: begin
          if (req_idx == '0) begin
            status.stop    <= 1'b0;
            status.segment <= req_segment;
            loop_cnt       <= '0;
            state          <= FINITE_LOOP;
          end
        end
        FINITE_LOOP: begin
          if (live_wrap) begin
            if (loop_cnt == rep) begin
              status.stop <= 1'b1;
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
        end
        INFINITE_LOOP: begin
          state <= INFINITE_LOOP;
        end
        default: begin
          state <= INFINITE_LOOP;
        end
      endcase
    end
  end

  // registered copies feed the buffer and the wrap detection
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      idx_0_out <= '0;
      idx_1_out <= '0;
    end else begin
      idx_0_out <= idx_0;
      idx_1_out <= idx_1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/modulation_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation_buffer
  import modulation_pkg::*;
#(
  parameter int SAMPLE_W = 8
) (
  input  wire logic                CLK,
  input  wire logic                arst_n,
  input  wire logic                wr_en,
  input  wire logic                wr_segment,
  input  wire logic [IDX_W-1:0]    wr_addr,
  input  wire logic [SAMPLE_W-1:0] wr_data,
  input  wire mod_status_t         status,
  input  wire logic [IDX_W-1:0]    idx_0_out,
  input  wire logic [IDX_W-1:0]    idx_1_out,
  output logic      [SAMPLE_W-1:0] sample
);

  localparam int DEPTH = 2 ** (IDX_W + 1);

  // segment number is the top address bit
  logic [SAMPLE_W-1:0] mem [DEPTH];

  logic [IDX_W-1:0] rd_idx;

  assign rd_idx = status.segment ? idx_1_out : idx_0_out;

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[{wr_segment, wr_addr}] <= wr_data;
    end
  end

  // stop is left to the downstream stage, the read keeps running
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sample <= '0;
    end else begin
      sample <= mem[{status.segment, rd_idx}];
    end
  end

endmodule

`default_nettype wire

// ==== logic/modulation.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation
  import modulation_pkg::*;
#(
  parameter int SAMPLE_W = 8
) (
  input  wire logic                CLK,
  input  wire logic                arst_n,
  input  wire logic                settings_req,
  input  wire mod_settings_t       settings,
  input  wire logic                wr_en,
  input  wire logic                wr_segment,
  input  wire logic [IDX_W-1:0]    wr_addr,
  input  wire logic [SAMPLE_W-1:0] wr_data,
  output logic                     settings_ack,
  output mod_status_t              status,
  output logic      [IDX_W-1:0]    idx_0_out,
  output logic      [IDX_W-1:0]    idx_1_out,
  output logic      [SAMPLE_W-1:0] sample
);

  mod_settings_t    cur_settings;
  logic             update;
  logic [IDX_W-1:0] idx_0;
  logic [IDX_W-1:0] idx_1;

  modulation_settings settings_i (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .settings_req (settings_req),
    .settings     (settings),
    .settings_ack (settings_ack),
    .update       (update),
    .cur_settings (cur_settings)
  );

  modulation_timer timer_i (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .cur_settings (cur_settings),
    .idx_0        (idx_0),
    .idx_1        (idx_1)
  );

  modulation_swapchain swapchain_i (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .update       (update),
    .cur_settings (cur_settings),
    .idx_0        (idx_0),
    .idx_1        (idx_1),
    .status       (status),
    .idx_0_out    (idx_0_out),
    .idx_1_out    (idx_1_out)
  );

  modulation_buffer #(
    .SAMPLE_W (SAMPLE_W)
  ) buffer_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_segment (wr_segment),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .status     (status),
    .idx_0_out  (idx_0_out),
    .idx_1_out  (idx_1_out),
    .sample     (sample)
  );

endmodule

`default_nettype wire

// ==== tb/modulation_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation_chk
  import modulation_pkg::*;
(
  input wire logic        CLK,
  input wire logic        arst_n,
  input wire logic        settings_req,
  input wire logic        settings_ack,
  input wire logic        update,
  input wire mod_status_t status,
  input wire swap_state_t state
);

  a_update_pulse: assert property (@(posedge CLK) disable iff (!arst_n)
    update |=> !update)
    else $error("update held for more than one cycle");

  a_ack_needs_req: assert property (@(posedge CLK) disable iff (!arst_n)
    $rose(settings_ack) |-> $past(settings_req))
    else $error("settings_ack rose without settings_req");

  // a deferred swap clears stop when it lands, long after its update
  a_stop_clear: assert property (@(posedge CLK) disable iff (!arst_n)
    $fell(status.stop) |-> $past(update) || $past(state == WAIT_START))
    else $error("stop fell without an update or a swap");

  a_segment_change: assert property (@(posedge CLK) disable iff (!arst_n)
    (status.segment != $past(status.segment)) |-> $past(update) || $past(state == WAIT_START))
    else $error("segment changed outside an update or the end of WAIT_START");

endmodule

bind modulation modulation_chk chk_i (
  .CLK          (CLK),
  .arst_n       (arst_n),
  .settings_req (settings_req),
  .settings_ack (settings_ack),
  .update       (update),
  .status       (status),
  .state        (swapchain_i.state)
);

`default_nettype wire

// ==== tb/modulation_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation_tb
  import modulation_pkg::*;
();

  localparam int SAMPLE_W    = 8;
  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int SEED        = 15484;
  localparam int WAIT_LIMIT  = 600;
  // a long test is about 4 repeats of 16 samples at 8 clocks, six tests and a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  localparam mod_status_t SEG0_RUN  = '{segment: 1'b0, stop: 1'b0};
  localparam mod_status_t SEG0_STOP = '{segment: 1'b0, stop: 1'b1};
  localparam mod_status_t SEG1_RUN  = '{segment: 1'b1, stop: 1'b0};

  logic                CLK;
  logic                arst_n;
  logic                settings_req;
  mod_settings_t       settings;
  logic                wr_en;
  logic                wr_segment;
  logic [IDX_W-1:0]    wr_addr;
  logic [SAMPLE_W-1:0] wr_data;
  logic                settings_ack;
  mod_status_t         status;
  logic [IDX_W-1:0]    idx_0_out;
  logic [IDX_W-1:0]    idx_1_out;
  logic [SAMPLE_W-1:0] sample;

  logic [SAMPLE_W-1:0] ref_mem [2][16];
  mod_settings_t       base;
  int                  errors;
  int                  test_start;
  int                  tests_ok;
  int                  tests_bad;
  int                  cycles;

  modulation #(
    .SAMPLE_W (SAMPLE_W)
  ) dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    $display("the run timed out after %0d cycles before all tests finished", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic step();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  task automatic check_status(input string name, input mod_status_t got, input mod_status_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_idx(input string name, input logic [IDX_W-1:0] got,
                           input logic [IDX_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] got,
                              input logic [SAMPLE_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == test_start) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d check(s) wrong", name, errors - test_start);
    end
  endtask

  task automatic raise_req(input mod_settings_t s);
    settings     = s;
    settings_req = 1'b1;
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (settings_ack !== level && n < 16) begin
      step();
      n++;
    end
    if (settings_ack !== level) begin
      $display("settings_ack did not reach %b within 16 cycles", level);
      errors++;
    end
  endtask

  task automatic send_settings(input mod_settings_t s);
    raise_req(s);
    wait_ack(1'b1);
    settings_req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic load_samples();
    for (int seg = 0; seg < 2; seg++) begin
      for (int a = 0; a < 16; a++) begin
        ref_mem[seg[0]][a[3:0]] = SAMPLE_W'($urandom());
        wr_en      = 1'b1;
        wr_segment = seg[0];
        wr_addr    = IDX_W'(a);
        wr_data    = ref_mem[seg[0]][a[3:0]];
        step();
      end
    end
    wr_en = 1'b0;
  endtask

  // the sample lags the live segment and index by one cycle
  task automatic compare_samples(input int n);
    logic             seg;
    logic [IDX_W-1:0] idx;
    seg = status.segment;
    idx = seg ? idx_1_out : idx_0_out;
    for (int i = 0; i < n; i++) begin
      step();
      check_sample("sample", sample, ref_mem[seg][idx[3:0]]);
      seg = status.segment;
      idx = seg ? idx_1_out : idx_0_out;
    end
  endtask

  // idx_1_out steps once every div_1 + 1 clocks and wraps after cycle_1
  task automatic watch_idx_1_steps(input int n);
    logic [IDX_W-1:0] prev;
    logic [IDX_W-1:0] want;
    int               held;
    int               changes;
    prev    = idx_1_out;
    held    = 0;
    changes = 0;
    for (int i = 0; i < n; i++) begin
      step();
      held++;
      if (idx_1_out !== prev) begin
        want = (prev == base.cycle_1) ? '0 : prev + 1'b1;
        check_idx("idx_1_out", idx_1_out, want);
        if (changes > 0 && held != int'(base.div_1) + 1) begin
          $display("idx_1_out held its value %0d cycles instead of %0d",
                   held, int'(base.div_1) + 1);
          errors++;
        end
        changes++;
        held = 0;
        prev = idx_1_out;
      end
    end
    if (changes == 0) begin
      $display("idx_1_out never stepped");
      errors++;
    end
  endtask

  task automatic test_reset_state();
    test_start = errors;
    check_status("status", status, SEG0_RUN);
    check_flag("settings_ack", settings_ack, 1'b0);
    check_idx("idx_0_out", idx_0_out, '0);
    check_sample("sample", sample, '0);
    finish_test("reset state");
  endtask

  task automatic test_handshake();
    mod_settings_t s;
    test_start    = errors;
    s             = base;
    s.req_segment = 1'b1;
    raise_req(s);
    step();
    check_flag("settings_ack", settings_ack, 1'b0);
    check_status("status", status, SEG0_RUN);
    step();
    check_flag("settings_ack", settings_ack, 1'b1);
    check_status("status", status, SEG1_RUN);
    step();
    check_flag("settings_ack", settings_ack, 1'b1);
    settings_req = 1'b0;
    step();
    check_flag("settings_ack", settings_ack, 1'b0);
    check_status("status", status, SEG1_RUN);
    finish_test("handshake");
  endtask

  task automatic test_deferred_swap();
    int   n;
    logic swapped;
    test_start = errors;
    n          = 0;
    swapped    = 1'b0;
    // the request must arrive while segment 0 is mid-cycle so the swap has to wait
    while (idx_0_out == '0 && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (idx_0_out == '0) begin
      $display("idx_0_out stayed at zero before the deferred swap");
      errors++;
    end
    n = 0;
    raise_req(base);
    while (!swapped && n < WAIT_LIMIT) begin
      step();
      n++;
      if (settings_ack) settings_req = 1'b0;
      if (status.segment == 1'b0) swapped = 1'b1;
    end
    if (!swapped) begin
      $display("the deferred swap to segment 0 never landed");
      errors++;
    end else begin
      check_idx("idx_0_out", idx_0_out, '0);
      check_status("status", status, SEG0_RUN);
    end
    settings_req = 1'b0;
    wait_ack(1'b0);
    finish_test("deferred swap");
  endtask

  task automatic test_repeat_count();
    int               n;
    int               k;
    int               returns;
    logic [IDX_W-1:0] prev;
    test_start = errors;
    n          = 0;
    returns    = 0;
    prev       = idx_0_out;
    while (returns < 3 && n < WAIT_LIMIT) begin
      step();
      n++;
      if (prev != '0 && idx_0_out == '0) returns++;
      prev = idx_0_out;
      if (returns < 3) check_status("status", status, SEG0_RUN);
    end
    if (returns < 3) begin
      $display("idx_0_out came back to zero only %0d times", returns);
      errors++;
    end else begin
      k = 0;
      while (!status.stop && k < 2) begin
        step();
        k++;
      end
      check_status("status", status, SEG0_STOP);
    end
    finish_test("repeat count");
  endtask

  task automatic test_rerequest();
    test_start = errors;
    raise_req(base);
    step();
    check_status("status", status, SEG0_STOP);
    step();
    check_status("status", status, SEG0_RUN);
    check_flag("settings_ack", settings_ack, 1'b1);
    settings_req = 1'b0;
    wait_ack(1'b0);
    check_status("status", status, SEG0_RUN);
    finish_test("re-request of current segment");
  endtask

  task automatic test_sample_path();
    mod_settings_t s;
    test_start    = errors;
    s             = base;
    s.req_segment = 1'b1;
    load_samples();
    compare_samples(160);
    send_settings(s);
    compare_samples(80);
    watch_idx_1_steps(40);
    check_status("status", status, SEG1_RUN);
    finish_test("sample path");
  endtask

  initial begin
    arst_n       = 1'b0;
    settings_req = 1'b0;
    settings     = '0;
    wr_en        = 1'b0;
    wr_segment   = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    errors       = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    void'($urandom(SEED));

    // segment 0 has 16 samples at 8 clocks and two repeats, segment 1 loops forever
    base             = '0;
    base.rep_0       = 32'd2;
    base.rep_1       = REP_INFINITE;
    base.cycle_0     = IDX_W'(15);
    base.cycle_1     = IDX_W'(7);
    base.div_0       = 16'd7;
    base.div_1       = 16'd3;

    repeat (3) @(posedge CLK);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    test_reset_state();
    test_handshake();
    test_deferred_swap();
    test_repeat_count();
    test_rerequest();
    test_sample_path();

    $display("summary: %0d tests ok, %0d tests wrong, %0d failed checks",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== modulation.f ====
logic/modulation_pkg.sv
logic/modulation_settings.sv
logic/modulation_timer.sv
logic/modulation_swapchain.sv
logic/modulation_buffer.sv
logic/modulation.sv
tb/modulation_chk.sv
tb/modulation_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module modulation_tb \
		-f modulation.f --Mdir obj_dir -o modulation_sim

run: compile
	./obj_dir/modulation_sim | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
